/* src/aes_config.svh */
`ifndef AES_CONFIG_SVH
`define AES_CONFIG_SVH

// Block and key width, AES-128 only
`define AES_BLOCK_W 128

// One state column, also one key schedule word
`define AES_WORD_W 32

// Expanded key size in words, (rounds + 1) * 4
`define AES_NUM_RK_WORDS 44

// Enough bits to address every round-key word
`define AES_RK_IDX_W 6

// Full rounds after the initial AddRoundKey
`define AES_NUM_ROUNDS 10

// Columns per state
`define AES_COLS 4

`endif

/* src/aes_pkg.sv */
`include "aes_config.svh"

package aes_pkg;

    typedef logic [`AES_WORD_W-1:0] word_t;

    // Column 0 sits in the top word
    typedef logic [`AES_BLOCK_W-1:0] block_t;

    typedef logic [`AES_RK_IDX_W-1:0] rk_idx_t;

    typedef enum logic [2:0] {
        IDLE,
        KEY_EXPAND,
        ROUND0,
        SUB,
        SHIFT_MIX,
        DONE
    } ctrl_state_t;

    ////////////////////////////////////////////////////////////////////////////
    // Forward S-box, entry 0 in the top byte
    ////////////////////////////////////////////////////////////////////////////
    localparam logic [2047:0] SBOX_TABLE = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    // 255 - b is ~b for a byte
    function automatic logic [7:0] sbox(input logic [7:0] b);
        return SBOX_TABLE[{~b, 3'b000} +: 8];
    endfunction

    // SubBytes on all four bytes of one word
    function automatic word_t sub_word(input word_t w);
        word_t r;
        for (int i = 0; i < 4; i++) begin
            r[8*i +: 8] = sbox(w[8*i +: 8]);
        end
        return r;
    endfunction

    // Multiply by x in GF(2^8)
    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

endpackage

/* src/aes_key_expand.sv */
`timescale 1ns/1ps
`include "aes_config.svh"

module aes_key_expand (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            key_start,
    input  aes_pkg::block_t key_in,
    output logic            key_valid,
    output logic            key_last,
    output aes_pkg::rk_idx_t key_index,
    output aes_pkg::word_t  key_word
);

    localparam aes_pkg::rk_idx_t LAST_IDX = aes_pkg::rk_idx_t'(`AES_NUM_RK_WORDS - 1);

    logic             busy;
    aes_pkg::rk_idx_t cnt;
    logic [7:0]       rcon;
    // win[0] is word cnt, win[3] is word cnt + 3
    aes_pkg::word_t   win [`AES_COLS];
    aes_pkg::word_t   rot_sub;
    aes_pkg::word_t   next_word;

    // RotWord, SubWord and Rcon for word cnt + 4
    assign rot_sub   = aes_pkg::sub_word({win[3][23:0], win[3][31:24]}) ^ {rcon, 24'h0};
    assign next_word = win[0] ^ ((cnt[1:0] == 2'b00) ? rot_sub : win[3]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            cnt       <= '0;
            rcon      <= 8'h00;
            key_valid <= 1'b0;
            key_last  <= 1'b0;
            key_index <= '0;
        end else begin
            key_valid <= busy;
            key_last  <= busy && (cnt == LAST_IDX);
            key_index <= cnt;
            if (key_start) begin
                busy <= 1'b1;
                cnt  <= '0;
                rcon <= 8'h01;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt[1:0] == 2'b00) begin
                    rcon <= aes_pkg::xtime(rcon);
                end
                if (cnt == LAST_IDX) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // Sliding window of the last four words
    always_ff @(posedge clk) begin
        if (key_start) begin
            for (int i = 0; i < `AES_COLS; i++) begin
                win[i] <= key_in[(`AES_COLS - 1 - i) * `AES_WORD_W +: `AES_WORD_W];
            end
        end else if (busy) begin
            win[0] <= win[1];
            win[1] <= win[2];
            win[2] <= win[3];
            win[3] <= next_word;
        end
        key_word <= win[0];
    end

    a_index_range: assert property (@(posedge clk) disable iff (!rst_n)
        key_valid |-> key_index <= LAST_IDX);

endmodule

/* src/aes_round_key_store.sv */
`timescale 1ns/1ps
`include "aes_config.svh"

module aes_round_key_store (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wr_en,
    input  aes_pkg::rk_idx_t wr_index,
    input  aes_pkg::word_t   wr_word,
    input  aes_pkg::rk_idx_t rd_index,
    output aes_pkg::word_t   rd_word
);

    aes_pkg::word_t rk [`AES_NUM_RK_WORDS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `AES_NUM_RK_WORDS; i++) begin
                rk[i] <= '0;
            end
        end else if (wr_en) begin
            rk[wr_index] <= wr_word;
        end
    end

    // Unused index codes read as zero
    always_comb begin
        rd_word = '0;
        if (rd_index < `AES_NUM_RK_WORDS) begin
            rd_word = rk[rd_index];
        end
    end

    a_wr_range: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> wr_index < `AES_NUM_RK_WORDS);

    // Controller counters never point past the schedule
    a_rd_range: assert property (@(posedge clk) disable iff (!rst_n)
        rd_index < `AES_NUM_RK_WORDS);

endmodule

/* src/aes_column_datapath.sv */
`timescale 1ns/1ps
`include "aes_config.svh"

module aes_column_datapath (
    input  aes_pkg::block_t aes_state,
    input  aes_pkg::block_t temp_state,
    input  logic [1:0]      col,
    input  aes_pkg::word_t  round_key,
    input  logic            last_round,
    output aes_pkg::word_t  ark_col,
    output aes_pkg::word_t  sub_col,
    output aes_pkg::word_t  round_col
);

    aes_pkg::word_t state_col;
    aes_pkg::word_t shifted_col;
    aes_pkg::word_t mixed_col;

    // Column c starts at bit (3 - c) * 32
    function automatic aes_pkg::word_t get_col(input aes_pkg::block_t s, input logic [1:0] c);
        return s[{~c, 5'b00000} +: `AES_WORD_W];
    endfunction

    function automatic aes_pkg::word_t mix_col(input aes_pkg::word_t a);
        logic [7:0] a0, a1, a2, a3;
        a0 = a[31:24];
        a1 = a[23:16];
        a2 = a[15:8];
        a3 = a[7:0];
        return {aes_pkg::xtime(a0) ^ aes_pkg::xtime(a1) ^ a1 ^ a2 ^ a3,
                a0 ^ aes_pkg::xtime(a1) ^ aes_pkg::xtime(a2) ^ a2 ^ a3,
                a0 ^ a1 ^ aes_pkg::xtime(a2) ^ aes_pkg::xtime(a3) ^ a3,
                aes_pkg::xtime(a0) ^ a0 ^ a1 ^ a2 ^ aes_pkg::xtime(a3)};
    endfunction

    assign state_col = get_col(aes_state, col);
    assign ark_col   = state_col ^ round_key;
    assign sub_col   = aes_pkg::sub_word(state_col);

    // ShiftRows for one output column, row r comes from column col + r
    always_comb begin
        logic [1:0]     src;
        aes_pkg::word_t src_word;
        for (int r = 0; r < `AES_COLS; r++) begin
            src      = col + 2'(r);
            src_word = get_col(temp_state, src);
            shifted_col[(3 - r) * 8 +: 8] = src_word[(3 - r) * 8 +: 8];
        end
    end

    assign mixed_col = mix_col(shifted_col);

    // Last round has no MixColumns
    assign round_col = (last_round ? shifted_col : mixed_col) ^ round_key;

endmodule

/* src/aes_enc_ctrl.sv */
`timescale 1ns/1ps
`include "aes_config.svh"

module aes_enc_ctrl (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  aes_pkg::block_t  data_in,
    input  logic             key_last,
    input  aes_pkg::word_t   ark_col,
    input  aes_pkg::word_t   sub_col,
    input  aes_pkg::word_t   round_col,
    output logic             key_start,
    output aes_pkg::block_t  aes_state,
    output aes_pkg::block_t  temp_state,
    output logic [1:0]       col,
    output logic             last_round,
    output aes_pkg::rk_idx_t rd_index,
    output aes_pkg::block_t  data_out,
    output logic             ready
);

    aes_pkg::ctrl_state_t state;
    logic [3:0]           round_cnt;
    logic [1:0]           col_cnt;
    logic                 col_last;
    logic [6:0]           col_lsb;

    assign col        = col_cnt;
    assign col_last   = (col_cnt == 2'(`AES_COLS - 1));
    assign last_round = (round_cnt == 4'(`AES_NUM_ROUNDS));
    // round * 4 + column
    assign rd_index   = aes_pkg::rk_idx_t'({round_cnt, col_cnt});
    assign col_lsb    = {~col_cnt, 5'b00000};

    ////////////////////////////////////////////////////////////////////////////
    // Round FSM
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= aes_pkg::IDLE;
            round_cnt <= '0;
            col_cnt   <= '0;
            key_start <= 1'b0;
            ready     <= 1'b0;
            data_out  <= '0;
        end else begin
            key_start <= 1'b0;
            case (state)
                aes_pkg::IDLE: begin
                    ready <= 1'b0;
                    if (start) begin
                        round_cnt <= '0;
                        col_cnt   <= '0;
                        key_start <= 1'b1;
                        state     <= aes_pkg::KEY_EXPAND;
                    end
                end
                // Store takes word 43 on the same edge
                aes_pkg::KEY_EXPAND: begin
                    if (key_last) begin
                        state <= aes_pkg::ROUND0;
                    end
                end
                aes_pkg::ROUND0: begin
                    col_cnt <= col_cnt + 1'b1;
                    if (col_last) begin
                        round_cnt <= 4'd1;
                        state     <= aes_pkg::SUB;
                    end
                end
                aes_pkg::SUB: begin
                    col_cnt <= col_cnt + 1'b1;
                    if (col_last) begin
                        state <= aes_pkg::SHIFT_MIX;
                    end
                end
                aes_pkg::SHIFT_MIX: begin
                    col_cnt <= col_cnt + 1'b1;
                    if (col_last) begin
                        if (last_round) begin
                            state <= aes_pkg::DONE;
                        end else begin
                            round_cnt <= round_cnt + 1'b1;
                            state     <= aes_pkg::SUB;
                        end
                    end
                end
                // Hold the result until start drops
                aes_pkg::DONE: begin
                    data_out <= aes_state;
                    ready    <= 1'b1;
                    if (!start) begin
                        state <= aes_pkg::IDLE;
                    end
                end
                default: state <= aes_pkg::IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Cipher state, one column per cycle
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        case (state)
            aes_pkg::IDLE: begin
                if (start) begin
                    aes_state <= data_in;
                end
            end
            aes_pkg::ROUND0:    aes_state[col_lsb +: `AES_WORD_W] <= ark_col;
            aes_pkg::SUB:       temp_state[col_lsb +: `AES_WORD_W] <= sub_col;
            aes_pkg::SHIFT_MIX: aes_state[col_lsb +: `AES_WORD_W] <= round_col;
            default: ;
        endcase
    end

    // Ready is high only on the cycle right after a DONE cycle
    a_ready_from_done: assert property (@(posedge clk) disable iff (!rst_n)
        ready |-> $past(state == aes_pkg::DONE));

endmodule

/* src/aes_enc_core.sv */
`timescale 1ns/1ps

module aes_enc_core (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  aes_pkg::block_t data_in,
    input  aes_pkg::block_t key_in,
    output aes_pkg::block_t data_out,
    output logic            ready
);

    logic             key_start;
    logic             key_valid;
    logic             key_last;
    aes_pkg::rk_idx_t key_index;
    aes_pkg::word_t   key_word;
    aes_pkg::rk_idx_t rd_index;
    aes_pkg::word_t   rd_word;
    aes_pkg::block_t  aes_state;
    aes_pkg::block_t  temp_state;
    logic [1:0]       col;
    logic             last_round;
    aes_pkg::word_t   ark_col;
    aes_pkg::word_t   sub_col;
    aes_pkg::word_t   round_col;

    aes_key_expand u_key_expand (
        .clk       (clk),
        .rst_n     (rst_n),
        .key_start (key_start),
        .key_in    (key_in),
        .key_valid (key_valid),
        .key_last  (key_last),
        .key_index (key_index),
        .key_word  (key_word)
    );

    aes_round_key_store u_round_key_store (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (key_valid),
        .wr_index (key_index),
        .wr_word  (key_word),
        .rd_index (rd_index),
        .rd_word  (rd_word)
    );

    aes_column_datapath u_column_datapath (
        .aes_state  (aes_state),
        .temp_state (temp_state),
        .col        (col),
        .round_key  (rd_word),
        .last_round (last_round),
        .ark_col    (ark_col),
        .sub_col    (sub_col),
        .round_col  (round_col)
    );

    aes_enc_ctrl u_enc_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .data_in    (data_in),
        .key_last   (key_last),
        .ark_col    (ark_col),
        .sub_col    (sub_col),
        .round_col  (round_col),
        .key_start  (key_start),
        .aes_state  (aes_state),
        .temp_state (temp_state),
        .col        (col),
        .last_round (last_round),
        .rd_index   (rd_index),
        .data_out   (data_out),
        .ready      (ready)
    );

endmodule

/* dv/aes_enc_tb.sv */
`timescale 1ns/1ps

module aes_enc_tb;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 4;
    localparam int SEED         = 8365;
    localparam int IDLE_CYCLES  = 10;
    localparam int NUM_OPS      = 5;
    localparam int OP_CYCLES    = 150;
    localparam int MAX_GAP      = 7;
    localparam int HOLD_CYCLES  = 6;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + IDLE_CYCLES
                                  + NUM_OPS * (OP_CYCLES + MAX_GAP + HOLD_CYCLES);

    // FIPS-197 appendix C.1 vector
    localparam aes_pkg::block_t KEY_C1 = 128'h000102030405060708090a0b0c0d0e0f;
    localparam aes_pkg::block_t PT_C1  = 128'h00112233445566778899aabbccddeeff;
    localparam aes_pkg::block_t CT_C1  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

    // FIPS-197 appendix B vector
    localparam aes_pkg::block_t KEY_B  = 128'h2b7e151628aed2a6abf7158809cf4f3c;
    localparam aes_pkg::block_t PT_B   = 128'h3243f6a8885a308d313198a2e0370734;
    localparam aes_pkg::block_t CT_B   = 128'h3925841d02dc09fbdc118597196a0b32;

    // All-zero key and block
    localparam aes_pkg::block_t CT_ZERO = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;

    logic            clk;
    logic            rst_n;
    logic            start;
    aes_pkg::block_t data_in;
    aes_pkg::block_t key_in;
    aes_pkg::block_t data_out;
    logic            ready;

    string           cur_test;
    aes_pkg::block_t exp_result;
    logic            started;
    int              error_count;
    int              errors_at_test_start;
    int              tests_passed;
    int              tests_failed;
    int              cycle_count;

    aes_enc_core u_aes_enc_core (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .data_in  (data_in),
        .key_in   (key_in),
        .data_out (data_out),
        .ready    (ready)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Checks on the DUT outputs
    ////////////////////////////////////////////////////////////////////////////

    // Quiet outputs until the first operation
    a_idle_ready: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> !ready)
    else begin
        $display("ready went high before any start was given");
        error_count++;
    end

    a_idle_data: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> data_out == '0)
    else begin
        $display("Error: %s expected %h actual %h", cur_test, 128'h0, $sampled(data_out));
        error_count++;
    end

    // Ciphertext against the known answer
    a_result: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ready) |-> data_out == exp_result)
    else begin
        $display("Error: %s expected %h actual %h", cur_test, exp_result,
                 $sampled(data_out));
        error_count++;
    end

    // Result holds while start stays high
    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ready && start && $past(start) |=> ready && $stable(data_out))
    else begin
        $display("ready or data_out changed in %s while start was still high", cur_test);
        error_count++;
    end

    a_release: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(start) && ready |-> ##2 !ready)
    else begin
        $display("ready was still high in %s two edges after start dropped", cur_test);
        error_count++;
    end

    // Run limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles in %s", cycle_count, cur_test);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    // Advance one cycle, landing just after the edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic begin_test(input string name);
        cur_test             = name;
        errors_at_test_start = error_count;
    endtask

    task automatic end_test();
        int errs;
        errs = error_count - errors_at_test_start;
        if (errs == 0) begin
            tests_passed++;
            $display("Test %s finished: ok", cur_test);
        end else begin
            tests_failed++;
            $display("Test %s finished: %0d errors", cur_test, errs);
        end
    endtask

    // One encryption, start held until ready plus hold cycles
    task automatic encrypt(input aes_pkg::block_t key, input aes_pkg::block_t pt,
                           input aes_pkg::block_t exp, input int hold);
        int gap;
        gap = $urandom % (MAX_GAP + 1);
        repeat (gap) tick();
        key_in     = key;
        data_in    = pt;
        exp_result = exp;
        start      = 1'b1;
        started    = 1'b1;
        tick();
        while (!ready) begin
            tick();
        end
        repeat (hold) tick();
        start = 1'b0;
        while (ready) begin
            tick();
        end
    endtask

    initial begin
        start                = 1'b0;
        data_in              = '0;
        key_in               = '0;
        rst_n                = 1'b0;
        exp_result           = '0;
        started              = 1'b0;
        cur_test             = "reset";
        error_count          = 0;
        errors_at_test_start = 0;
        tests_passed         = 0;
        tests_failed         = 0;
        cycle_count          = 0;
        void'($urandom(SEED));

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        begin_test("reset_idle");
        repeat (IDLE_CYCLES) tick();
        end_test();

        begin_test("fips197_c1");
        encrypt(KEY_C1, PT_C1, CT_C1, 1);
        end_test();

        begin_test("fips197_b");
        encrypt(KEY_B, PT_B, CT_B, 1);
        end_test();

        begin_test("hold_and_release");
        encrypt(KEY_B, PT_B, CT_B, HOLD_CYCLES);
        end_test();

        // Second run must not see anything left from the first
        begin_test("back_to_back");
        encrypt('0, '0, CT_ZERO, 1);
        encrypt(KEY_C1, PT_C1, CT_C1, 1);
        repeat (3) tick();
        end_test();

        $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+src
src/aes_pkg.sv
src/aes_key_expand.sv
src/aes_round_key_store.sv
src/aes_column_datapath.sv
src/aes_enc_ctrl.sv
src/aes_enc_core.sv
dv/aes_enc_tb.sv

/* Makefile */
VERILATOR  := verilator
VFLAGS     := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
TOP        := aes_enc_tb
RTL_TOP    := aes_enc_core
FILELIST   := project.f
OBJ_DIR    := obj_dir
PASS_TEXT  := *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the pass line in the simulator output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
